// ==== verilog.f ====
logic/sliceDefsPkg.sv
logic/regPortIf.sv
logic/aluSlice.sv
logic/multiPortRegFile.sv
logic/sliceSequencer.sv
logic/bitSliceUnit.sv
testbench/bitSliceUnit_props.sv
testbench/tbBitSliceUnit.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the bit-slice unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f \
    --top-module tbBitSliceUnit -o simBitSliceUnit
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/simBitSliceUnit 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "SIMULATION PASSED"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== testbench/tbBitSliceUnit.sv ====
/*
  Testbench for the bit-slice unit: four-phase host driver, register-file model and checker.
  Runs directed sequences and a seeded random command mix.
*/
`timescale 1ns/1ps

module tbBitSliceUnit;
    import sliceDefsPkg::*;

    localparam int ackTimeout  = 20;            // Cycles allowed per handshake phase
    localparam int randomCount = 200;           // Length of the random mix

    logic    clk0 = 1'b0;
    logic    arstN;
    logic    req;
    opcodeT  cmdOp;
    regAddrT srcA;
    regAddrT srcB;
    regAddrT dst;
    nibbleT  cmdData;
    logic    ack;
    nibbleT  result;
    logic    carry;
    logic    countOverflow;
    logic    equal;

    integer  seed = 32'hc730_3809;              // Fixed seed
    nibbleT  modelRegs [regCount];              // Register-file model
    logic    modelOverflow;
    nibbleT  expResult;                         // Expected for the current command
    logic    expCarry;
    logic    ackSeen;                           // Current ack pulse already counted
    int      ackRises;
    int      commandsIssued;

    always #5 clk0 = ~clk0;                     // 10 ns period

    bitSliceUnit dut_i (
        .clk0          (clk0),
        .arstN         (arstN),
        .req           (req),
        .cmdOp         (cmdOp),
        .srcA          (srcA),
        .srcB          (srcB),
        .dst           (dst),
        .cmdData       (cmdData),
        .ack           (ack),
        .result        (result),
        .carry         (carry),
        .countOverflow (countOverflow),
        .equal         (equal)
    );

    bind sliceSequencer bitSliceUnit_props props_i (
        .clk0  (clk0),
        .arstN (arstN),
        .req   (req),
        .ack   (ack),
        .state (state)
    );

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "Stopped at first failure");
    endtask

    task automatic checkValue(input string what, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            stopWithFailure($sformatf("[ERROR] time %0t: %s is 0x%0h, expected 0x%0h",
                                      $time, what, actual, expected));
        end
    endtask

    // Expected result and carry of one command, model updated in place
    function automatic void predictCommand(input opcodeT op, input regAddrT a,
                                           input regAddrT b, input regAddrT d,
                                           input nibbleT data, output nibbleT res,
                                           output logic cy);
        logic [dataWidth:0] wide;               // Sum with carry bit
        res = modelRegs[a];
        cy  = 1'b0;
        case (op)
            opLoad: res = data;
            opAdd: begin
                wide = {1'b0, modelRegs[a]} + {1'b0, modelRegs[b]};
                res  = wide[dataWidth-1:0];
                cy   = wide[dataWidth];
            end
            opSub: begin
                res = modelRegs[a] - modelRegs[b];
                cy  = (modelRegs[a] >= modelRegs[b]); // No borrow
            end
            opAnd: res = modelRegs[a] & modelRegs[b];
            opXor: res = modelRegs[a] ^ modelRegs[b];
            opCount: begin
                res           = modelRegs[0] + 4'd1;
                modelOverflow = (modelRegs[0] == 4'hf); // Set only on wrap
                modelRegs[0]  = res;
            end
            default: res = modelRegs[a];       // opRead
        endcase
        if (op inside {opLoad, opAdd, opSub, opAnd, opXor}) begin
            modelRegs[d] = res;
            if (d == '0) begin
                modelOverflow = 1'b0;           // Write to register 0 clears it
            end
        end
    endfunction

    // Full four-phase handshake, req kept high holdCycles after ack
    task automatic issueCommand(input opcodeT op, input regAddrT a, input regAddrT b,
                                input regAddrT d, input nibbleT data, input int holdCycles);
        nibbleT res;
        logic   cy;
        int     waited;
        @(posedge clk0);
        #1;
        predictCommand(op, a, b, d, data, res, cy);
        expResult = res;
        expCarry  = cy;
        cmdOp     = op;
        srcA      = a;
        srcB      = b;
        dst       = d;
        cmdData   = data;
        req       = 1'b1;
        commandsIssued++;
        waited = 0;
        while (!ack) begin
            @(negedge clk0);
            waited++;
            if (waited > ackTimeout) begin
                stopWithFailure("Timeout: ack never rose after req was raised");
            end
        end
        checkValue("ack rise latency", 32'(waited), 32'd4); // Accept, exec, ack
        for (int i = 0; i < holdCycles; i++) begin
            @(negedge clk0);
            checkValue("ack while req held", 32'(ack), 32'd1);
        end
        @(posedge clk0);
        #1;
        req    = 1'b0;
        waited = 0;
        while (ack) begin
            @(negedge clk0);
            waited++;
            if (waited > ackTimeout) begin
                stopWithFailure("Timeout: ack stayed high after req was dropped");
            end
        end
        checkValue("ack fall latency", 32'(waited), 32'd2);
    endtask

    task automatic issueRandomCommand();
        logic [31:0] r;
        r = $random(seed);
        issueCommand(opcodeT'(r[30:16] % 7), r[3:2], r[5:4], r[7:6], r[11:8],
                     (r[15:14] == 2'b11) ? 2 : 0);  // Occasional held req
    endtask

    // Outputs checked at the falling edge, away from DUT updates
    always @(negedge clk0) begin
        if (arstN && ack) begin
            checkValue("result", 32'(result), 32'(expResult));
            checkValue("carry", 32'(carry), 32'(expCarry));
            if (!ackSeen) begin
                ackRises++;
                ackSeen = 1'b1;
            end
        end else if (arstN && ackSeen) begin
            checkValue("equal", 32'(equal), 32'(modelRegs[0] == modelRegs[regCount-1]));
            checkValue("countOverflow", 32'(countOverflow), 32'(modelOverflow));
            ackSeen = 1'b0;
        end
    end

    initial begin
        logic [31:0] r;
        arstN          = 1'b0;
        req            = 1'b0;
        cmdOp          = opLoad;
        srcA           = '0;
        srcB           = '0;
        dst            = '0;
        cmdData        = '0;
        expResult      = '0;
        expCarry       = 1'b0;
        ackSeen        = 1'b0;
        ackRises       = 0;
        commandsIssued = 0;
        modelOverflow  = 1'b0;
        for (int i = 0; i < regCount; i++) begin
            modelRegs[i] = '0;
        end
        repeat (2) @(posedge clk0);
        #1;
        arstN = 1'b1;

        // Zero after reset, then load and read back
        for (int i = 0; i < regCount; i++) begin
            issueCommand(opRead, regAddrT'(i), '0, '0, '0, 0);
        end
        for (int i = 0; i < regCount; i++) begin
            issueCommand(opLoad, '0, '0, regAddrT'(i), nibbleT'(4 * i + 9), 0);
        end
        for (int i = 0; i < regCount; i++) begin
            issueCommand(opRead, regAddrT'(i), '0, '0, '0, 0);
        end

        // ALU ops on random registers, destination read back
        for (int i = 0; i < 24; i++) begin
            r = $random(seed);
            issueCommand(opLoad, '0, '0, r[9:8], r[13:10], 0);
            issueCommand(opAdd + opcodeT'(r[1:0]), r[3:2], r[5:4], r[7:6], '0, 0);
            issueCommand(opRead, r[7:6], '0, '0, '0, 0);
        end

        // Counter wraps from 13, overflow cleared by count and by write
        issueCommand(opLoad, '0, '0, 2'd0, 4'd13, 0);
        repeat (4) issueCommand(opCount, '0, '0, '0, '0, 0);
        issueCommand(opLoad, '0, '0, 2'd0, 4'd15, 0);
        issueCommand(opCount, '0, '0, '0, '0, 0);
        issueCommand(opLoad, '0, '0, 2'd0, 4'd6, 0);

        // Equal flag through load, count and ALU writes
        issueCommand(opLoad, '0, '0, 2'd3, 4'd6, 0);
        issueCommand(opCount, '0, '0, '0, '0, 0);
        issueCommand(opLoad, '0, '0, 2'd1, 4'd7, 0);
        issueCommand(opLoad, '0, '0, 2'd2, 4'd0, 0);
        issueCommand(opXor, 2'd1, 2'd2, 2'd3, '0, 0);
        issueCommand(opAnd, 2'd2, 2'd1, 2'd0, '0, 0);

        // Host holds req on an accumulating add, a repeat would change register 1
        issueCommand(opAdd, 2'd1, 2'd3, 2'd1, '0, 6);
        issueCommand(opRead, 2'd1, '0, '0, '0, 0);

        repeat (randomCount) issueRandomCommand();

        if (ackRises != commandsIssued) begin
            stopWithFailure($sformatf("Handshake count wrong: %0d acks for %0d commands",
                                      ackRises, commandsIssued));
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

// ==== testbench/bitSliceUnit_props.sv ====
/*
  Handshake and reset assertions, bound into the sequencer from the testbench.
*/
`timescale 1ns/1ps

module bitSliceUnit_props (
    input logic                   clk0,
    input logic                   arstN,
    input logic                   req,
    input logic                   ack,
    input sliceDefsPkg::seqStateT state
);
    import sliceDefsPkg::*;

    ackLowInReset: assert property (@(posedge clk0) !arstN |-> !ack)
        else $error("ack high while reset is active");

    // ack only answers a pending req
    ackNeedsReq: assert property (@(posedge clk0) disable iff (!arstN)
        $rose(ack) |-> $past(req))
        else $error("ack rose without req");

    ackHeldWithReq: assert property (@(posedge clk0) disable iff (!arstN)
        (ack && req) |=> ack)
        else $error("ack fell while req was still high");

    // No new command accepted under back-pressure
    doneHeldWithReq: assert property (@(posedge clk0) disable iff (!arstN)
        ((state == stDone) && req) |=> (state == stDone))
        else $error("Sequencer left the done state while req was high");

endmodule

// ==== logic/bitSliceUnit.sv ====
/*
  Top level of the bit-slice unit with plain host ports.
  Ties the sequencer, the four-port register file and the ALU together.
*/
`timescale 1ns/1ps

module bitSliceUnit (
    input  logic                  clk0,
    input  logic                  arstN,
    input  logic                  req,
    input  sliceDefsPkg::opcodeT  cmdOp,
    input  sliceDefsPkg::regAddrT srcA,
    input  sliceDefsPkg::regAddrT srcB,
    input  sliceDefsPkg::regAddrT dst,
    input  sliceDefsPkg::nibbleT  cmdData,
    output logic                  ack,
    output sliceDefsPkg::nibbleT  result,
    output logic                  carry,
    output logic                  countOverflow,
    output logic                  equal
);
    import sliceDefsPkg::*;

    nibbleT aluResult;                  // ALU output, written through port C
    logic   aluCarry;
    logic   countIn;                    // Count strobe for register 0

    regPortIf portA ();
    regPortIf portB ();
    regPortIf portC ();
    regPortIf portX ();

    sliceSequencer seq_i (
        .clk0      (clk0),
        .arstN     (arstN),
        .req       (req),
        .ack       (ack),
        .cmdOp     (cmdOp),
        .srcA      (srcA),
        .srcB      (srcB),
        .dst       (dst),
        .cmdData   (cmdData),
        .aluResult (aluResult),
        .aluCarry  (aluCarry),
        .countIn   (countIn),
        .result    (result),
        .carry     (carry),
        .portA     (portA),
        .portB     (portB),
        .portC     (portC),
        .portX     (portX)
    );

    multiPortRegFile regFile_i (
        .clk0          (clk0),
        .arstN         (arstN),
        .portA         (portA),
        .portB         (portB),
        .portC         (portC),
        .portX         (portX),
        .countIn       (countIn),
        .countOverflow (countOverflow),
        .equal         (equal)
    );

    // Host holds cmdOp stable for the whole handshake
    aluSlice alu_i (
        .op       (cmdOp),
        .a        (portA.rdData),
        .b        (portB.rdData),
        .y        (aluResult),
        .carryOut (aluCarry)
    );

endmodule

// ==== logic/sliceSequencer.sv ====
/*
  Four-phase req/ack command FSM for the bit-slice unit.
  Latches the command, strobes the register-file ports for one cycle, holds the result.
*/
`timescale 1ns/1ps

module sliceSequencer (
    input  logic                  clk0,
    input  logic                  arstN,
    input  logic                  req,
    output logic                  ack,
    input  sliceDefsPkg::opcodeT  cmdOp,
    input  sliceDefsPkg::regAddrT srcA,
    input  sliceDefsPkg::regAddrT srcB,
    input  sliceDefsPkg::regAddrT dst,
    input  sliceDefsPkg::nibbleT  cmdData,
    input  sliceDefsPkg::nibbleT  aluResult,
    input  logic                  aluCarry,
    output logic                  countIn,
    output sliceDefsPkg::nibbleT  result,
    output logic                  carry,
    regPortIf.ctrl                portA,
    regPortIf.ctrl                portB,
    regPortIf.ctrl                portC,
    regPortIf.ctrl                portX
);
    import sliceDefsPkg::*;

    seqStateT state;
    opcodeT   opReg;                    // Latched command
    regAddrT  srcAReg;
    regAddrT  srcBReg;
    regAddrT  dstReg;
    nibbleT   dataReg;
    logic     execOn;                   // The single strobe cycle
    logic     isAluOp;
    nibbleT   captureData;              // Value for result at end of stExec
    logic     captureCarry;

    // Command fields taken when req is accepted
    always_ff @(posedge clk0) begin
        if ((state == stIdle) && req) begin
            opReg   <= cmdOp;
            srcAReg <= srcA;
            srcBReg <= srcB;
            dstReg  <= dst;
            dataReg <= cmdData;
        end
    end

    always_ff @(posedge clk0 or negedge arstN) begin
        if (!arstN) begin
            state  <= stIdle;
            ack    <= 1'b0;
            result <= '0;
            carry  <= 1'b0;
        end else begin
            case (state)
                stIdle: if (req) state <= stExec;
                stExec: begin
                    state  <= stDone;
                    result <= captureData;
                    carry  <= captureCarry;
                end
                stDone: begin
                    if (!req) begin
                        state <= stIdle;
                        ack   <= 1'b0;  // Drops on the edge req is seen low
                    end else begin
                        ack   <= 1'b1;  // Held while host keeps req
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    assign execOn  = (state == stExec);
    assign isAluOp = (opReg == opAdd) || (opReg == opSub) ||
                     (opReg == opAnd) || (opReg == opXor);

    // Result source per command, carry only from add and sub
    always_comb begin
        captureData  = aluResult;
        captureCarry = 1'b0;
        case (opReg)
            opLoad:       captureData  = dataReg;
            opRead:       captureData  = portX.rdData;
            opCount:      captureData  = portX.rdData + nibbleT'(1); // New register 0 value
            opAdd, opSub: captureCarry = aluCarry;
            default:      captureCarry = 1'b0;
        endcase
    end

    // Ports A and B feed the ALU operands, read only
    assign portA.en     = execOn & isAluOp;
    assign portA.wrEn   = 1'b0;
    assign portA.addr   = srcAReg;
    assign portA.wrData = '0;
    assign portB.en     = execOn & isAluOp;
    assign portB.wrEn   = 1'b0;
    assign portB.addr   = srcBReg;
    assign portB.wrData = '0;

    // Port C writes the ALU result back
    assign portC.en     = execOn & isAluOp;
    assign portC.wrEn   = execOn & isAluOp;
    assign portC.addr   = dstReg;
    assign portC.wrData = aluResult;

    // Port X is the host path: load, read back, and count readout
    assign portX.en     = execOn & ((opReg == opLoad) || (opReg == opRead) ||
                                    (opReg == opCount));
    assign portX.wrEn   = execOn & (opReg == opLoad);
    assign portX.addr   = (opReg == opLoad)  ? dstReg :
                          (opReg == opCount) ? regAddrT'(0) : srcAReg;
    assign portX.wrData = dataReg;

    assign countIn = execOn & (opReg == opCount);

endmodule

// ==== logic/multiPortRegFile.sv ====
/*
  Four-port 4x4 register file, flip-flop based, write priority A > B > C > X.
  Register 0 also counts on countIn; equal flags register 0 matching register 3.
*/
`timescale 1ns/1ps

module multiPortRegFile (
    input  logic  clk0,
    input  logic  arstN,
    regPortIf.mem portA,
    regPortIf.mem portB,
    regPortIf.mem portC,
    regPortIf.mem portX,
    input  logic  countIn,
    output logic  countOverflow,
    output logic  equal
);
    import sliceDefsPkg::*;

    nibbleT  regs     [regCount];       // Register array
    logic    portWe   [portCount];      // Per-port write request
    regAddrT portAddr [portCount];
    nibbleT  portData [portCount];
    logic    wrSel    [regCount];       // Some port writes this register
    nibbleT  wrVal    [regCount];       // Winning write data

    // Reads are combinational, gated by the port enable
    assign portA.rdData = portA.en ? regs[portA.addr] : '0;
    assign portB.rdData = portB.en ? regs[portB.addr] : '0;
    assign portC.rdData = portC.en ? regs[portC.addr] : '0;
    assign portX.rdData = portX.en ? regs[portX.addr] : '0;

    // Index 0 is the highest priority
    assign portWe[0]   = portA.en & portA.wrEn;
    assign portWe[1]   = portB.en & portB.wrEn;
    assign portWe[2]   = portC.en & portC.wrEn;
    assign portWe[3]   = portX.en & portX.wrEn;
    assign portAddr[0] = portA.addr;
    assign portAddr[1] = portB.addr;
    assign portAddr[2] = portC.addr;
    assign portAddr[3] = portX.addr;
    assign portData[0] = portA.wrData;
    assign portData[1] = portB.wrData;
    assign portData[2] = portC.wrData;
    assign portData[3] = portX.wrData;

    // Per-register write select, scanned from X up to A so A wins
    always_comb begin
        for (int r = 0; r < regCount; r++) begin
            wrSel[r] = 1'b0;
            wrVal[r] = regs[r];
            for (int p = portCount - 1; p >= 0; p--) begin
                if (portWe[p] && (portAddr[p] == regAddrT'(r))) begin
                    wrSel[r] = 1'b1;
                    wrVal[r] = portData[p];
                end
            end
        end
    end

    // Register 0: counter has precedence over any port write
    always_ff @(posedge clk0 or negedge arstN) begin
        if (!arstN) begin
            regs[0]       <= '0;
            countOverflow <= 1'b0;
        end else if (countIn) begin
            {countOverflow, regs[0]} <= regs[0] + (dataWidth + 1)'(1); // Carry out marks wrap
        end else if (wrSel[0]) begin
            regs[0]       <= wrVal[0];
            countOverflow <= 1'b0;      // Fresh value, no overflow
        end
    end

    // Registers 1 to 3 are plain storage
    always_ff @(posedge clk0 or negedge arstN) begin
        if (!arstN) begin
            for (int r = 1; r < regCount; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int r = 1; r < regCount; r++) begin
                if (wrSel[r]) begin
                    regs[r] <= wrVal[r];
                end
            end
        end
    end

    assign equal = (regs[0] == regs[regCount-1]); // Register 0 against register 3

endmodule

// ==== logic/aluSlice.sv ====
/*
  Combinational 4-bit ALU slice: add, subtract, AND, XOR with carry out.
  Unknown codes pass operand a through.
*/
`timescale 1ns/1ps

module aluSlice (
    input  sliceDefsPkg::opcodeT op,
    input  sliceDefsPkg::nibbleT a,
    input  sliceDefsPkg::nibbleT b,
    output sliceDefsPkg::nibbleT y,
    output logic                 carryOut
);
    import sliceDefsPkg::*;

    logic [dataWidth:0] sum;            // a + b with carry
    logic [dataWidth:0] diff;           // a + ~b + 1, top bit is no-borrow

    assign sum  = {1'b0, a} + {1'b0, b};
    assign diff = {1'b0, a} + {1'b0, ~b} + (dataWidth + 1)'(1);

    always_comb begin
        y        = a;                   // Passthrough by default
        carryOut = 1'b0;
        case (op)
            opAdd: begin
                y        = sum[dataWidth-1:0];
                carryOut = sum[dataWidth];
            end
            opSub: begin
                y        = diff[dataWidth-1:0];
                carryOut = diff[dataWidth]; // High when a >= b
            end
            opAnd: begin
                y = a & b;
            end
            opXor: begin
                y = a ^ b;
            end
            default: begin
                y        = a;
                carryOut = 1'b0;
            end
        endcase
    end

endmodule

// ==== logic/regPortIf.sv ====
/*
  One register-file port: enable, write enable, address, write data and read data.
  The sequencer takes the ctrl side, the register file the mem side.
*/
`timescale 1ns/1ps

interface regPortIf;
    import sliceDefsPkg::*;

    logic    en;                        // Port enable
    logic    wrEn;                      // Write strobe, qualified by en
    regAddrT addr;                      // Register select
    nibbleT  wrData;                    // Data to write
    nibbleT  rdData;                    // Zero when en is low

    modport ctrl (
        output en,
        output wrEn,
        output addr,
        output wrData,
        input  rdData
    );

    modport mem (
        input  en,
        input  wrEn,
        input  addr,
        input  wrData,
        output rdData
    );

endinterface

// ==== logic/sliceDefsPkg.sv ====
/*
  Shared widths, data types, command codes and sequencer states for the bit-slice unit.
  Imported by every RTL file and by the testbench.
*/
package sliceDefsPkg;

    localparam int dataWidth = 4;       // One data nibble
    localparam int regCount  = 4;       // Registers in the file
    localparam int addrWidth = 2;       // Register address bits
    localparam int portCount = 4;       // Ports A, B, C, X

    typedef logic [dataWidth-1:0] nibbleT;     // Data word
    typedef logic [addrWidth-1:0] regAddrT;    // Register address
    typedef logic [2:0]           opcodeT;     // Command code

    // Host command codes
    localparam opcodeT opLoad  = 3'd0;  // dst <= cmdData
    localparam opcodeT opRead  = 3'd1;  // result <= srcA
    localparam opcodeT opAdd   = 3'd2;  // dst <= srcA + srcB
    localparam opcodeT opSub   = 3'd3;  // dst <= srcA - srcB
    localparam opcodeT opAnd   = 3'd4;  // dst <= srcA & srcB
    localparam opcodeT opXor   = 3'd5;  // dst <= srcA ^ srcB
    localparam opcodeT opCount = 3'd6;  // Register 0 counts up

    // Sequencer FSM
    typedef enum logic [1:0] {
        stIdle,                         // Waiting for req
        stExec,                         // One cycle of port strobes
        stDone                          // ack held until req drops
    } seqStateT;

endpackage
